/* ising_pkg.sv */
package ising_pkg;

    //////////////////////////////////////////////////
    // Sizes
    //////////////////////////////////////////////////
    localparam int NUM_SPIN = 8;
    localparam int BIT_J    = 4;
    localparam int HOST_DW  = NUM_SPIN * BIT_J;
    localparam int HOST_AW  = 8;
    localparam int ENERGY_W = 16;
    localparam int J_AW     = 3;
    // Wide enough for the largest flip memory
    localparam int FLIP_AW  = 4;

    // Register offsets inside region 0
    localparam logic [1:0] REG_CTRL      = 2'd0;
    localparam logic [1:0] REG_STATUS    = 2'd1;
    localparam logic [1:0] REG_SPIN_ADDR = 2'd2;
    localparam logic [1:0] REG_ENERGY    = 2'd3;

    // Regions, top two address bits
    localparam logic [1:0] REGION_REG  = 2'd0;
    localparam logic [1:0] REGION_J    = 2'd1;
    localparam logic [1:0] REGION_FLIP = 2'd2;

    //////////////////////////////////////////////////
    // Bus and memory payloads
    //////////////////////////////////////////////////
    typedef struct packed {
        logic [HOST_AW-1:0] addr;
        logic               write;
        logic [HOST_DW-1:0] wdata;
    } host_req_t;

    typedef struct packed {
        logic [HOST_DW-1:0] rdata;
    } host_rsp_t;

    // Host view is a raw word, engine view is one coupling per spin
    typedef union packed {
        logic [HOST_DW-1:0]                   raw;
        logic signed [NUM_SPIN-1:0][BIT_J-1:0] j;
    } j_row_u;

    typedef struct packed {
        logic            en;
        logic            we;
        logic [J_AW-1:0] addr;
        j_row_u          wdata;
    } j_mem_req_t;

    typedef struct packed {
        logic                en;
        logic                we;
        logic [FLIP_AW-1:0]  addr;
        logic [NUM_SPIN-1:0] wdata;
    } flip_mem_req_t;

    typedef struct packed {
        logic                       busy;
        logic                       done;
        logic signed [ENERGY_W-1:0] energy;
    } engine_status_t;

endpackage

/* l1_sram.sv */
`timescale 1ns/1ns

module l1_sram #(
    parameter int DEPTH  = 16,
    parameter int WIDTH  = 8,
    parameter int ADDR_W = $clog2(DEPTH)
) (
    input  logic              clk_i,
    input  logic              en_i,
    input  logic              we_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  logic [WIDTH-1:0]  wdata_i,
    output logic [WIDTH-1:0]  rdata_o
);

    logic [WIDTH-1:0] mem [DEPTH];

    // Read data holds until the next enabled read
    always_ff @(posedge clk_i) begin
        if (en_i) begin
            if (we_i) begin
                mem[addr_i] <= wdata_i;
            end else begin
                rdata_o <= mem[addr_i];
            end
        end
    end

    // Requesters wrap or decode addresses to the real depth
    assert property (@(posedge clk_i) en_i |-> (addr_i < DEPTH))
        else $error("memory access beyond depth %0d at address %0d", DEPTH, addr_i);

endmodule

/* l1_port_mux.sv */
`timescale 1ns/1ns

module l1_port_mux import ising_pkg::*; (
    // Engine side
    input  logic          eng_busy_i,
    input  j_mem_req_t    eng_j_req_i,
    input  flip_mem_req_t eng_flip_req_i,

    // Host side
    input  j_mem_req_t    host_j_req_i,
    input  flip_mem_req_t host_flip_req_i,
    output logic          host_gnt_o,

    // Memory ports
    output j_mem_req_t    j_mem_req_o,
    output flip_mem_req_t flip_mem_req_o
);

    //////////////////////////////////////////////////
    // Port ownership
    //////////////////////////////////////////////////
    always_comb begin
        if (eng_busy_i) begin
            j_mem_req_o    = eng_j_req_i;
            flip_mem_req_o = eng_flip_req_i;
        end else begin
            j_mem_req_o    = host_j_req_i;
            flip_mem_req_o = host_flip_req_i;
        end
    end

    // Host owns both ports whenever no sweep runs
    assign host_gnt_o = ~eng_busy_i;

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////
    // Register front end must hold its requests until granted
    always_comb begin
        if (eng_busy_i) begin
            assert (!host_j_req_i.en && !host_flip_req_i.en)
                else $error("host memory request raised while the engine owns the ports");
        end
    end

endmodule

/* ising_reg_if.sv */
`timescale 1ns/1ns

module ising_reg_if import ising_pkg::*; (
    input  logic                clk_i,
    input  logic                reset_i,

    // Host bus
    input  logic                host_req_i,
    input  host_req_t           host_req_data_i,
    output logic                host_ack_o,
    output host_rsp_t           host_rsp_o,

    // Memory requests through the port mux
    input  logic                host_gnt_i,
    output j_mem_req_t          host_j_req_o,
    output flip_mem_req_t       host_flip_req_o,
    input  j_row_u              j_rdata_i,
    input  logic [NUM_SPIN-1:0] flip_rdata_i,

    // Engine control
    input  engine_status_t      status_i,
    output logic                start_o,
    output logic [FLIP_AW-1:0]  spin_addr_o
);

    localparam logic [2:0] S_IDLE    = 3'd0;
    localparam logic [2:0] S_ACCESS  = 3'd1;
    localparam logic [2:0] S_WAIT    = 3'd2;
    localparam logic [2:0] S_ACK     = 3'd3;
    localparam logic [2:0] S_RELEASE = 3'd4;

    logic [2:0]         state_q;
    logic [2:0]         state_d;
    logic [1:0]         region;
    logic [1:0]         reg_sel;
    logic               is_mem;
    logic               issue;
    logic               reg_wr;
    logic [HOST_DW-1:0] reg_rdata;
    logic [HOST_DW-1:0] rdata_q;
    logic [FLIP_AW-1:0] spin_addr_q;
    logic               start_q;

    assign region  = host_req_data_i.addr[HOST_AW-1 -: 2];
    assign reg_sel = host_req_data_i.addr[1:0];
    assign is_mem  = (region == REGION_J) || (region == REGION_FLIP);
    assign issue   = (state_q == S_ACCESS) && is_mem && host_gnt_i;
    assign reg_wr  = (state_q == S_ACCESS) && (region == REGION_REG) && host_req_data_i.write;

    //////////////////////////////////////////////////
    // Four-phase handshake
    //////////////////////////////////////////////////
    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE:    if (host_req_i) state_d = S_ACCESS;
            // Memory regions stall here while a sweep runs
            S_ACCESS:  if (!is_mem || host_gnt_i) state_d = S_WAIT;
            S_WAIT:    state_d = S_ACK;
            S_ACK:     if (!host_req_i) state_d = S_RELEASE;
            S_RELEASE: state_d = S_IDLE;
            default:   state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q     <= S_IDLE;
            spin_addr_q <= '0;
            start_q     <= 1'b0;
        end else begin
            state_q <= state_d;
            // A start while busy is dropped
            start_q <= reg_wr && (reg_sel == REG_CTRL) && host_req_data_i.wdata[0]
                       && !status_i.busy;
            if (reg_wr && (reg_sel == REG_SPIN_ADDR)) begin
                spin_addr_q <= host_req_data_i.wdata[FLIP_AW-1:0];
            end
        end
    end

    assign host_ack_o  = (state_q == S_ACK);
    assign start_o     = start_q;
    assign spin_addr_o = spin_addr_q;

    //////////////////////////////////////////////////
    // Memory requests and read data
    //////////////////////////////////////////////////
    always_comb begin
        host_j_req_o.en        = issue && (region == REGION_J);
        host_j_req_o.we        = host_req_data_i.write;
        host_j_req_o.addr      = host_req_data_i.addr[J_AW-1:0];
        host_j_req_o.wdata.raw = host_req_data_i.wdata;

        host_flip_req_o.en    = issue && (region == REGION_FLIP);
        host_flip_req_o.we    = host_req_data_i.write;
        host_flip_req_o.addr  = host_req_data_i.addr[FLIP_AW-1:0];
        host_flip_req_o.wdata = host_req_data_i.wdata[NUM_SPIN-1:0];
    end

    always_comb begin
        case (reg_sel)
            REG_STATUS:    reg_rdata = {{(HOST_DW-2){1'b0}}, status_i.done, status_i.busy};
            REG_SPIN_ADDR: reg_rdata = HOST_DW'(spin_addr_q);
            REG_ENERGY:    reg_rdata = {{(HOST_DW-ENERGY_W){status_i.energy[ENERGY_W-1]}},
                                        status_i.energy};
            default:       reg_rdata = '0;
        endcase
    end

    // Memory data is valid one cycle after the issue
    always_ff @(posedge clk_i) begin
        if (state_q == S_WAIT) begin
            case (region)
                REGION_REG:  rdata_q <= reg_rdata;
                REGION_J:    rdata_q <= j_rdata_i.raw;
                REGION_FLIP: rdata_q <= HOST_DW'(flip_rdata_i);
                default:     rdata_q <= '0;
            endcase
        end
    end

    assign host_rsp_o.rdata = rdata_q;

    assert property (@(posedge clk_i) disable iff (reset_i)
        host_req_i && $past(host_req_i) |-> $stable(host_req_data_i))
        else $error("host payload changed while req was high");

endmodule

/* ising_energy_engine.sv */
`timescale 1ns/1ns

module ising_energy_engine import ising_pkg::*; #(
    parameter int FLIP_DEPTH = 16
) (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                start_i,
    input  logic [FLIP_AW-1:0]  spin_addr_i,
    output j_mem_req_t          j_req_o,
    input  j_row_u              j_rdata_i,
    output flip_mem_req_t       flip_req_o,
    input  logic [NUM_SPIN-1:0] flip_rdata_i,
    output engine_status_t      status_o
);

    // Local field range is NUM_SPIN times the largest coupling
    localparam int H_W   = BIT_J + $clog2(NUM_SPIN) + 1;
    localparam int CNT_W = J_AW + 1;

    localparam logic [2:0] S_IDLE   = 3'd0;
    localparam logic [2:0] S_FETCH  = 3'd1;
    localparam logic [2:0] S_STREAM = 3'd2;
    localparam logic [2:0] S_WRITE  = 3'd3;
    localparam logic [2:0] S_DONE   = 3'd4;

    logic [2:0]                 state_q;
    logic                       busy;
    logic [CNT_W-1:0]           row_cnt_q;
    logic                       issue_row;
    logic                       row_valid_q;
    logic [J_AW-1:0]            row_idx_q;
    logic                       last_row;
    logic [FLIP_AW-1:0]         src_addr_q;
    logic [FLIP_AW-1:0]         dst_addr;
    logic [NUM_SPIN-1:0]        spin_q;
    logic [NUM_SPIN-1:0]        new_spin_q;
    logic signed [H_W-1:0]      tree [NUM_SPIN];
    logic signed [H_W-1:0]      h_sum;
    logic signed [ENERGY_W-1:0] energy_q;

    assign busy      = (state_q == S_FETCH) || (state_q == S_STREAM) || (state_q == S_WRITE);
    assign issue_row = (state_q == S_STREAM) && (row_cnt_q < CNT_W'(NUM_SPIN));
    assign last_row  = row_valid_q && (row_idx_q == J_AW'(NUM_SPIN - 1));
    assign dst_addr  = (src_addr_q + FLIP_AW'(1)) & FLIP_AW'(FLIP_DEPTH - 1);

    //////////////////////////////////////////////////
    // Local field of the returning row
    //////////////////////////////////////////////////
    always_comb begin
        for (int j = 0; j < NUM_SPIN; j++) begin
            tree[j] = H_W'($signed(j_rdata_i.j[j]));
            if (!spin_q[j]) begin
                tree[j] = -tree[j];
            end
        end
        // Pairwise reduction, log2(NUM_SPIN) levels
        for (int w = NUM_SPIN / 2; w > 0; w = w / 2) begin
            for (int k = 0; k < w; k++) begin
                tree[k] = tree[2*k] + tree[2*k+1];
            end
        end
        h_sum = tree[0];
    end

    //////////////////////////////////////////////////
    // Sweep FSM
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q     <= S_IDLE;
            row_cnt_q   <= '0;
            row_valid_q <= 1'b0;
            energy_q    <= '0;
        end else begin
            row_valid_q <= issue_row;
            case (state_q)
                S_IDLE, S_DONE: begin
                    if (start_i) begin
                        state_q  <= S_FETCH;
                        energy_q <= '0;
                    end
                end
                S_FETCH: begin
                    state_q   <= S_STREAM;
                    row_cnt_q <= '0;
                end
                S_STREAM: begin
                    if (issue_row) begin
                        row_cnt_q <= row_cnt_q + CNT_W'(1);
                    end
                    // E = -sum sigma_i * h_i
                    if (row_valid_q) begin
                        energy_q <= spin_q[row_idx_q] ? energy_q - h_sum : energy_q + h_sum;
                    end
                    if (last_row) begin
                        state_q <= S_WRITE;
                    end
                end
                S_WRITE: state_q <= S_DONE;
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        row_idx_q <= row_cnt_q[J_AW-1:0];
        if (start_i && !busy) begin
            src_addr_q <= spin_addr_i & FLIP_AW'(FLIP_DEPTH - 1);
        end
        // Source vector arrives in the first stream cycle
        if ((state_q == S_STREAM) && (row_cnt_q == '0)) begin
            spin_q <= flip_rdata_i;
        end
        if (row_valid_q) begin
            new_spin_q[row_idx_q] <= (h_sum >= 0);
        end
    end

    //////////////////////////////////////////////////
    // Memory requests and status
    //////////////////////////////////////////////////
    always_comb begin
        j_req_o.en        = issue_row;
        j_req_o.we        = 1'b0;
        j_req_o.addr      = row_cnt_q[J_AW-1:0];
        j_req_o.wdata.raw = '0;

        flip_req_o.en    = (state_q == S_FETCH) || (state_q == S_WRITE);
        flip_req_o.we    = (state_q == S_WRITE);
        flip_req_o.addr  = (state_q == S_WRITE) ? dst_addr : src_addr_q;
        flip_req_o.wdata = new_spin_q;
    end

    assign status_o.busy   = busy;
    assign status_o.done   = (state_q == S_DONE);
    assign status_o.energy = energy_q;

    assert property (@(posedge clk_i) disable iff (reset_i) busy |-> !start_i)
        else $error("start pulse reached the engine during a sweep");

endmodule

/* ising_core_top.sv */
`timescale 1ns/1ns

module ising_core_top import ising_pkg::*; #(
    parameter int FLIP_DEPTH = 16
) (
    input  logic      clk_i,
    input  logic      reset_i,
    input  logic      host_req_i,
    input  host_req_t host_req_data_i,
    output logic      host_ack_o,
    output host_rsp_t host_rsp_o
);

    j_mem_req_t          host_j_req;
    j_mem_req_t          eng_j_req;
    j_mem_req_t          j_mem_req;
    flip_mem_req_t       host_flip_req;
    flip_mem_req_t       eng_flip_req;
    flip_mem_req_t       flip_mem_req;
    logic                host_gnt;
    j_row_u              j_rdata;
    logic [NUM_SPIN-1:0] flip_rdata;
    engine_status_t      eng_status;
    logic                start;
    logic [FLIP_AW-1:0]  spin_addr;

    //////////////////////////////////////////////////
    // Register front end
    //////////////////////////////////////////////////
    ising_reg_if u_reg_if (
        .clk_i           (clk_i          ),
        .reset_i         (reset_i        ),
        .host_req_i      (host_req_i     ),
        .host_req_data_i (host_req_data_i),
        .host_ack_o      (host_ack_o     ),
        .host_rsp_o      (host_rsp_o     ),
        .host_gnt_i      (host_gnt       ),
        .host_j_req_o    (host_j_req     ),
        .host_flip_req_o (host_flip_req  ),
        .j_rdata_i       (j_rdata        ),
        .flip_rdata_i    (flip_rdata     ),
        .status_i        (eng_status     ),
        .start_o         (start          ),
        .spin_addr_o     (spin_addr      )
    );

    l1_port_mux u_port_mux (
        .eng_busy_i      (eng_status.busy),
        .eng_j_req_i     (eng_j_req      ),
        .eng_flip_req_i  (eng_flip_req   ),
        .host_j_req_i    (host_j_req     ),
        .host_flip_req_i (host_flip_req  ),
        .host_gnt_o      (host_gnt       ),
        .j_mem_req_o     (j_mem_req      ),
        .flip_mem_req_o  (flip_mem_req   )
    );

    //////////////////////////////////////////////////
    // L1 memories and compute
    //////////////////////////////////////////////////
    l1_sram #(.DEPTH(NUM_SPIN), .WIDTH(HOST_DW)) u_j_mem (
        .clk_i   (clk_i          ),
        .en_i    (j_mem_req.en   ),
        .we_i    (j_mem_req.we   ),
        .addr_i  (j_mem_req.addr ),
        .wdata_i (j_mem_req.wdata),
        .rdata_o (j_rdata        )
    );

    l1_sram #(.DEPTH(FLIP_DEPTH), .WIDTH(NUM_SPIN), .ADDR_W(FLIP_AW)) u_flip_mem (
        .clk_i   (clk_i             ),
        .en_i    (flip_mem_req.en   ),
        .we_i    (flip_mem_req.we   ),
        .addr_i  (flip_mem_req.addr ),
        .wdata_i (flip_mem_req.wdata),
        .rdata_o (flip_rdata        )
    );

    ising_energy_engine #(.FLIP_DEPTH(FLIP_DEPTH)) u_engine (
        .clk_i        (clk_i       ),
        .reset_i      (reset_i     ),
        .start_i      (start       ),
        .spin_addr_i  (spin_addr   ),
        .j_req_o      (eng_j_req   ),
        .j_rdata_i    (j_rdata     ),
        .flip_req_o   (eng_flip_req),
        .flip_rdata_i (flip_rdata  ),
        .status_o     (eng_status  )
    );

endmodule

/* tb_ising_tasks.svh */
`ifndef TB_ISING_TASKS_SVH
`define TB_ISING_TASKS_SVH

//////////////////////////////////////////////////
// Stimulus and bus access
//////////////////////////////////////////////////
// Galois LFSR, one step per bit taken
function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int b = 0; b < n; b++) begin
        v      = {v[30:0], lfsr_q[0]};
        lfsr_q = (lfsr_q >> 1) ^ (lfsr_q[0] ? 32'h8020_0003 : 32'h0);
    end
    return v;
endfunction

task automatic wait_ack(logic level);
    int cycles;
    cycles = 0;
    while (host_ack !== level) begin
        if (cycles == ACK_LIMIT) begin
            $display("host ack did not %s within %0d cycles", level ? "rise" : "fall", ACK_LIMIT);
            abort_run();
        end
        @(negedge clk);
        cycles++;
    end
endtask

// Four-phase access, ack sampled on the falling edge
task automatic bus_access(input logic [HOST_AW-1:0] addr, input logic write,
                          input logic [HOST_DW-1:0] wdata, output logic [HOST_DW-1:0] rdata);
    @(negedge clk);
    host_req_data = '{addr: addr, write: write, wdata: wdata};
    host_req      = 1'b1;
    wait_ack(1'b1);
    rdata    = host_rsp.rdata;
    host_req = 1'b0;
    wait_ack(1'b0);
endtask

task automatic bus_write(input logic [HOST_AW-1:0] addr, input logic [HOST_DW-1:0] wdata);
    logic [HOST_DW-1:0] ignored;
    bus_access(addr, 1'b1, wdata, ignored);
endtask

task automatic bus_read(input logic [HOST_AW-1:0] addr, output logic [HOST_DW-1:0] rdata);
    bus_access(addr, 1'b0, '0, rdata);
endtask

//////////////////////////////////////////////////
// Compare tasks
//////////////////////////////////////////////////
task automatic report_mismatch(string name, logic [HOST_DW-1:0] got, logic [HOST_DW-1:0] exp);
    $display("ERR %s got %h expected %h", name, got, exp);
    abort_run();
endtask

task automatic check_row(string name, j_row_u got, j_row_u exp);
    if (got.raw !== exp.raw) report_mismatch(name, got.raw, exp.raw);
endtask

// Flip words read back zero-extended
task automatic check_spins(string name, logic [HOST_DW-1:0] got, logic [NUM_SPIN-1:0] exp);
    if (got !== HOST_DW'(exp)) report_mismatch(name, got, HOST_DW'(exp));
endtask

task automatic check_status(string name, logic [HOST_DW-1:0] got, engine_status_t exp);
    if (got !== HOST_DW'({exp.done, exp.busy})) begin
        report_mismatch(name, got, HOST_DW'({exp.done, exp.busy}));
    end
endtask

task automatic check_energy(string name, logic [HOST_DW-1:0] got,
                            logic signed [ENERGY_W-1:0] exp);
    if (got !== HOST_DW'(exp)) report_mismatch(name, got, HOST_DW'(exp));
endtask

`endif

/* tb_ising_core.sv */
`timescale 1ns/1ns

module tb_ising_core import ising_pkg::*; ();

    localparam int FLIP_DEPTH   = 16;
    localparam int ACK_LIMIT    = 64;
    // Memory readback test is the longest
    localparam int NUM_TESTS    = 5;
    localparam int MAX_ACCESSES = 48;
    localparam int WATCHDOG_NS  = NUM_TESTS * MAX_ACCESSES * ACK_LIMIT * 4;
    localparam logic [HOST_AW-1:0] J_BASE    = {REGION_J, 6'b0};
    localparam logic [HOST_AW-1:0] FLIP_BASE = {REGION_FLIP, 6'b0};

    logic                clk;
    logic                reset;
    logic                host_req;
    host_req_t           host_req_data;
    logic                host_ack;
    host_rsp_t           host_rsp;
    logic [31:0]         lfsr_q;
    j_row_u              j_model [NUM_SPIN];
    logic [NUM_SPIN-1:0] flip_model [FLIP_DEPTH];

    ising_core_top #(.FLIP_DEPTH(FLIP_DEPTH)) DUT (
        .clk_i           (clk          ),
        .reset_i         (reset        ),
        .host_req_i      (host_req     ),
        .host_req_data_i (host_req_data),
        .host_ack_o      (host_ack     ),
        .host_rsp_o      (host_rsp     )
    );

    always #2 clk = ~clk;

    task automatic abort_run();
        $display("Simulation FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    `include "tb_ising_tasks.svh"

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////
    // h_i = sum over j of J[i][j] * sigma_j
    function automatic int local_field(int i, logic [NUM_SPIN-1:0] spins);
        int h;
        int c;
        h = 0;
        for (int j = 0; j < NUM_SPIN; j++) begin
            c = $signed(j_model[i].raw[BIT_J*j +: BIT_J]);
            h += spins[j] ? c : -c;
        end
        return h;
    endfunction

    function automatic logic signed [ENERGY_W-1:0] model_energy(logic [NUM_SPIN-1:0] spins);
        int e;
        e = 0;
        for (int i = 0; i < NUM_SPIN; i++) begin
            e -= spins[i] ? local_field(i, spins) : -local_field(i, spins);
        end
        return e[ENERGY_W-1:0];
    endfunction

    function automatic logic [NUM_SPIN-1:0] model_update(logic [NUM_SPIN-1:0] spins);
        logic [NUM_SPIN-1:0] s;
        for (int i = 0; i < NUM_SPIN; i++) begin
            s[i] = (local_field(i, spins) >= 0);
        end
        return s;
    endfunction

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////
    task automatic wait_done();
        logic [HOST_DW-1:0] rd;
        rd = '0;
        for (int polls = 0; !rd[1]; polls++) begin
            if (polls == 32) begin
                $display("sweep did not report done within 32 status polls");
                abort_run();
            end
            bus_read(REG_STATUS, rd);
        end
    endtask

    task automatic check_j_memory();
        j_row_u rd;
        for (int r = 0; r < NUM_SPIN; r++) begin
            bus_read(J_BASE + HOST_AW'(r), rd.raw);
            check_row($sformatf("j[%0d]", r), rd, j_model[r]);
        end
    endtask

    task automatic test_reset_values();
        logic [HOST_DW-1:0] rd;
        bus_read(REG_STATUS, rd);
        check_status("STATUS", rd, '0);
        bus_read(REG_ENERGY, rd);
        check_energy("ENERGY", rd, '0);
    endtask

    task automatic test_memory_readback();
        logic [HOST_DW-1:0] rd;
        for (int r = 0; r < NUM_SPIN; r++) begin
            j_model[r].raw = rand_bits(HOST_DW);
            bus_write(J_BASE + HOST_AW'(r), j_model[r].raw);
        end
        for (int w = 0; w < FLIP_DEPTH; w++) begin
            flip_model[w] = rand_bits(NUM_SPIN);
            bus_write(FLIP_BASE + HOST_AW'(w), HOST_DW'(flip_model[w]));
        end
        check_j_memory();
        for (int w = 0; w < FLIP_DEPTH; w++) begin
            bus_read(FLIP_BASE + HOST_AW'(w), rd);
            check_spins($sformatf("flip[%0d]", w), rd, flip_model[w]);
        end
    endtask

    // Sweep from a fresh source vector with energy and write-back checked
    task automatic run_sweep(int src);
        logic [HOST_DW-1:0] rd;
        int                 dst;
        dst = (src + 1) % FLIP_DEPTH;
        flip_model[src] = rand_bits(NUM_SPIN);
        bus_write(FLIP_BASE + HOST_AW'(src), HOST_DW'(flip_model[src]));
        bus_write(REG_SPIN_ADDR, src);
        bus_write(REG_CTRL, 1);
        wait_done();
        bus_read(REG_ENERGY, rd);
        check_energy("ENERGY", rd, model_energy(flip_model[src]));
        flip_model[dst] = model_update(flip_model[src]);
        bus_read(FLIP_BASE + HOST_AW'(dst), rd);
        check_spins($sformatf("flip[%0d]", dst), rd, flip_model[dst]);
    endtask

    task automatic test_sweep_mid();
        run_sweep(5);
        check_j_memory();
    endtask

    task automatic test_sweep_wrap();
        logic [HOST_DW-1:0] rd;
        run_sweep(FLIP_DEPTH - 1);
        bus_write(REG_CTRL, 1);
        bus_read(REG_STATUS, rd);
        check_status("STATUS", rd, '{busy: 1'b1, done: 1'b0, energy: '0});
        wait_done();
        bus_read(FLIP_BASE, rd);
        check_spins("flip[0]", rd, flip_model[0]);
    endtask

    task automatic test_access_during_sweep();
        logic [HOST_DW-1:0] rd;
        flip_model[9]  = rand_bits(NUM_SPIN);
        flip_model[10] = model_update(flip_model[9]);
        bus_write(FLIP_BASE + HOST_AW'(9), HOST_DW'(flip_model[9]));
        bus_write(REG_SPIN_ADDR, 9);
        bus_write(REG_CTRL, 1);
        // Stalls until the port mux hands the ports back
        bus_read(FLIP_BASE + HOST_AW'(10), rd);
        check_spins("flip[10]", rd, flip_model[10]);
        // Repeat the sweep and aim a second start from address 3 at its write-back cycle
        bus_write(REG_CTRL, 1);
        bus_write(REG_SPIN_ADDR, 3);
        // Two idle cycles move the next access into the last busy cycle
        repeat (2) @(negedge clk);
        bus_write(REG_CTRL, 1);
        wait_done();
        bus_read(REG_STATUS, rd);
        check_status("STATUS", rd, '{busy: 1'b0, done: 1'b1, energy: '0});
        bus_read(REG_ENERGY, rd);
        check_energy("ENERGY", rd, model_energy(flip_model[9]));
        bus_read(FLIP_BASE + HOST_AW'(10), rd);
        check_spins("flip[10]", rd, flip_model[10]);
        bus_read(FLIP_BASE + HOST_AW'(4), rd);
        check_spins("flip[4]", rd, flip_model[4]);
    endtask

    //////////////////////////////////////////////////
    // Watchdog and sequence
    //////////////////////////////////////////////////
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns with tests still running", WATCHDOG_NS);
        abort_run();
    end

    initial begin
        clk           = 1'b0;
        reset         = 1'b1;
        host_req      = 1'b0;
        host_req_data = '0;
        lfsr_q        = 32'h52bb;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        test_reset_values();
        test_memory_readback();
        test_sweep_mid();
        test_sweep_wrap();
        test_access_during_sweep();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* ising_core_top.f */
+incdir+.
ising_pkg.sv
l1_sram.sv
l1_port_mux.sv
ising_reg_if.sv
ising_energy_engine.sv
ising_core_top.sv
tb_ising_core.sv

/* Bender.yml */
package:
  name: ising_core

sources:
  - files:
      - ising_pkg.sv
      - l1_sram.sv
      - l1_port_mux.sv
      - ising_reg_if.sv
      - ising_energy_engine.sv
      - ising_core_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_ising_core.sv
